//--- cache_sys.f
design/cache_pkg.sv
design/cache_way.sv
design/hit_write_buffer.sv
design/cache_ctrl.sv
design/cache_top.sv
verification/cache_assert.sv
verification/cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= cache_sys.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Done: no errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	$(BIN) > $(LOG) 2>&1; cat $(LOG); grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- verification/cache_tb.sv
`default_nettype none

module cache_tb;
    import cache_pkg::*;

    localparam int directed_reqs = 17;
    localparam int random_reqs   = 200;
    localparam int total_reqs    = directed_reqs + random_reqs;

    typedef struct packed {
        logic        is_read;
        logic [31:0] addr;
        logic [31:0] expect_data;
        logic [31:0] cyc;
    } pend_t;

    logic        clk;
    logic        resetn;
    logic        valid;
    cpu_req_t    req_in;
    logic        addr_ok;
    logic        data_ok;
    logic [31:0] rdata;
    logic        rd_req;
    logic [2:0]  rd_type;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    logic [31:0] ret_data;
    logic        wr_req;
    logic [2:0]  wr_type;
    logic [31:0] wr_addr;
    logic [3:0]  wr_wstrb;
    line_t       wr_data;
    logic        wr_rdy;

    logic [31:0] lfsr_q = 32'h973a;
    logic [31:0] cycle_cnt = '0;
    logic [31:0] last_latency = '0;
    logic [31:0] last_wr_addr = '0;
    int          wr_count = 0;
    int          error_count = 0;
    pend_t       pending[$];
    logic [31:0] shadow [logic [31:0]];                     // word address keyed
    logic [31:0] mem_words [logic [31:0]];

    cache_top UUT (
        .clk, .resetn, .valid, .req (req_in), .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_type, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_type, .wr_addr, .wr_wstrb, .wr_data, .wr_rdy
    );

    bind cache_ctrl cache_assert chk (.clk, .resetn, .wr_req, .rd_req, .rd_rdy,
                                      .data_ok, .state_q);

    always #4 clk = ~clk;

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // taps 32,22,2,1
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] init_word(input logic [31:0] waddr);
        return (waddr * 32'h9e37_79b1) ^ {waddr[15:0], waddr[31:16]} ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] new_w,
                                                input logic [3:0]  strb);
        logic [31:0] w;
        w = old_w;
        for (int i = 0; i < 4; i++)
        begin
            if (strb[i])
                w[8*i +: 8] = new_w[8*i +: 8];
        end
        return w;
    endfunction

    // expected word as the CPU should see it
    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [31:0] key;
        key = addr >> 2;
        return shadow.exists(key) ? shadow[key] : init_word(key);
    endfunction

    function automatic logic [31:0] mem_read(input logic [31:0] addr);
        logic [31:0] key;
        key = addr >> 2;
        return mem_words.exists(key) ? mem_words[key] : init_word(key);
    endfunction

    task automatic check_equal(input logic [127:0] got, input logic [127:0] expect_v,
                               input string what);
        if (got !== expect_v)
        begin
            error_count++;
            $display("[FAIL] %0t: %s, got %0h expected %0h", $time, what, got, expect_v);
            $display("Done: errors found");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic issue(input mem_op_t op, input logic [31:0] addr,
                         input logic [3:0] strb, input logic [31:0] data);
        pend_t e;
        #1;
        valid  = 1'b1;
        req_in = '{op: op, index: addr[11:4], tag: addr[31:12], offset: addr[3:0],
                   wstrb: strb, wdata: data};
        @(posedge clk);
        while (!addr_ok)
            @(posedge clk);
        e.is_read     = (op == op_read);
        e.addr        = addr;
        e.expect_data = (op == op_read) ? ref_word(addr) : 32'h0;
        e.cyc         = cycle_cnt;
        if (op == op_write)
            shadow[addr >> 2] = merge_bytes(ref_word(addr), data, strb);
        pending.push_back(e);
    endtask

    task automatic idle(input int n);
        if (n > 0)
        begin
            #1 valid = 1'b0;
            repeat (n) @(posedge clk);
        end
    endtask

    task automatic drain();
        #1 valid = 1'b0;
        do
            @(posedge clk);
        while (pending.size() != 0);
    endtask

    // responses arrive in request order
    always @(posedge clk)
    begin : compare
        pend_t e;
        if (resetn && data_ok)
        begin
            if (pending.size() == 0)
            begin
                $display("data_ok raised with no request outstanding at %0t", $time);
                $display("Done: errors found");
                $fatal(1, "unexpected response");
            end
            e = pending.pop_front();
            if (e.is_read)
            begin
                check_equal(rdata, e.expect_data, $sformatf("read of %h", e.addr));
                last_latency = cycle_cnt - e.cyc;
            end
        end
    end

    always @(posedge clk)
    begin : mem_write
        logic [127:0] line_exp;
        if (resetn && wr_req)
        begin
            for (int w = 0; w < 4; w++)
                line_exp[32*w +: 32] = ref_word(wr_addr + 32'(4*w));
            check_equal(wr_data, line_exp, "evicted line data");
            check_equal(wr_wstrb, 4'hf, "eviction byte strobes");
            check_equal(wr_type, burst_line, "write burst type");
            for (int w = 0; w < 4; w++)
                mem_words[(wr_addr >> 2) + 32'(w)] = wr_data[32*w +: 32];
            last_wr_addr = wr_addr;
            wr_count++;
        end
    end

    always @(posedge clk)
    begin
        #1 wr_rdy = (random_bits(2) != 0);                  // ready three times in four
    end

    initial
    begin : mem_read_port
        logic [31:0] base;
        logic [31:0] r;
        forever
        begin
            @(posedge clk);
            if (resetn && rd_req)
            begin
                base = rd_addr;
                check_equal(rd_type, burst_line, "read burst type");
                r    = random_bits(2);
                repeat (r[1:0]) @(posedge clk);
                #1 rd_rdy = 1'b1;
                @(posedge clk);
                #1 rd_rdy = 1'b0;
                for (int i = 0; i < 4; i++)
                begin
                    r = random_bits(1);
                    if (r[0])
                    begin
                        ret_valid = 1'b0;
                        @(posedge clk);
                        #1;
                    end
                    ret_valid = 1'b1;
                    ret_last  = (i == 3);
                    ret_data  = mem_read(base + 32'(4*i));
                    @(posedge clk);
                    #1;
                end
                ret_valid = 1'b0;
                ret_last  = 1'b0;
            end
        end
    end

    initial
    begin
        repeat (200 * total_reqs) @(posedge clk);
        $display("timeout: requests did not complete in time");
        $display("Done: errors found");
        $fatal(1, "watchdog expired");
    end

    initial
    begin
        logic [31:0] r;
        logic [31:0] addr;
        int          evict_before;
        clk       = 1'b0;
        resetn    = 1'b0;
        valid     = 1'b0;
        req_in    = '0;
        rd_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        wr_rdy    = 1'b0;
        repeat (5) @(posedge clk);
        #1 resetn = 1'b1;
        @(posedge clk);

        issue(op_read, 32'h0000_1040, 4'h0, 32'h0);         // miss then hit
        drain();
        issue(op_read, 32'h0000_1040, 4'h0, 32'h0);
        drain();
        check_equal(last_latency, 32'd1, "read hit latency");

        issue(op_write, 32'h0000_1040, 4'b0101, 32'hdead_beef);
        issue(op_read, 32'h0000_1040, 4'h0, 32'h0);         // same bank right behind
        drain();

        issue(op_write, 32'h0002_2084, 4'b1100, 32'h1234_5678);
        drain();
        issue(op_read, 32'h0002_2084, 4'h0, 32'h0);
        drain();

        evict_before = wr_count;
        issue(op_write, 32'h0010_0350, 4'hf, 32'haaaa_5555);
        drain();
        issue(op_write, 32'h0020_0354, 4'b0011, 32'h0bad_f00d);
        drain();
        issue(op_read, 32'h0030_0358, 4'h0, 32'h0);
        drain();
        check_equal(wr_count - evict_before, 1, "evictions at the third tag");
        check_equal(last_wr_addr, 32'h0010_0350, "victim address");

        for (int w = 0; w < 4; w++)
            issue(op_read, 32'h0030_0350 + 32'(4*w), 4'h0, 32'h0);
        for (int w = 0; w < 4; w++)
            issue(op_read, 32'h0020_0350 + 32'(4*w), 4'h0, 32'h0);
        drain();

        for (int n = 0; n < random_reqs; n++)
        begin
            r    = random_bits(5);
            addr = {20'h00040 + 20'(r[1:0]), 7'h08, r[2], r[4:3], 2'b00};
            r    = random_bits(1);
            if (r[0])
                issue(op_write, addr, 4'(random_bits(4)), random_bits(32));
            else
                issue(op_read, addr, 4'h0, 32'h0);
            r = random_bits(1);
            idle(int'(r[0]));
        end
        drain();

        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/cache_assert.sv
`default_nettype none

module cache_assert (
    input wire                          clk,
    input wire                          resetn,
    input wire                          wr_req,
    input wire                          rd_req,
    input wire                          rd_rdy,
    input wire                          data_ok,
    input wire cache_pkg::cache_state_t state_q
);
    import cache_pkg::*;

    // victim write is a single-cycle strobe
    wr_req_pulse: assert property (@(posedge clk) disable iff (!resetn)
        wr_req |=> !wr_req)
        else $error("wr_req high two cycles in a row");

    rd_req_hold: assert property (@(posedge clk) disable iff (!resetn)
        (rd_req && !rd_rdy) |=> rd_req)
        else $error("rd_req dropped before rd_rdy");

    // no response while the line is being replaced
    no_data_in_miss: assert property (@(posedge clk) disable iff (!resetn)
        !(data_ok && (state_q == s_miss || state_q == s_replace)))
        else $error("data_ok raised in s_miss or s_replace");

endmodule

`default_nettype wire

//--- design/cache_top.sv
`default_nettype none

module cache_top #(
    parameter int  num_sets   = 256,
    parameter int  line_words = 4,
    localparam int set_w      = $clog2(num_sets)
) (
    input  wire                           clk,
    input  wire                           resetn,
    input  wire                           valid,
    input  wire cache_pkg::cpu_req_t      req,
    output logic                          addr_ok,
    output logic                          data_ok,
    output logic [cache_pkg::word_w-1:0]  rdata,
    output logic                          rd_req,
    output logic [2:0]                    rd_type,
    output logic [31:0]                   rd_addr,
    input  wire                           rd_rdy,
    input  wire                           ret_valid,
    input  wire                           ret_last,
    input  wire [31:0]                    ret_data,
    output logic                          wr_req,
    output logic [2:0]                    wr_type,
    output logic [31:0]                   wr_addr,
    output logic [3:0]                    wr_wstrb,
    output cache_pkg::line_t              wr_data,
    input  wire                           wr_rdy
);
    import cache_pkg::*;

    tag_entry_t [1:0]  way_tag;
    line_t [1:0]       way_line;
    logic [1:0]        way_dirty;
    logic              bank_busy;
    logic              hit_write;
    way_wr_t           hit_entry;
    way_wr_t           wbuf;
    logic              wbuf_pending;
    logic              lookup_en;
    logic [set_w-1:0]  lookup_index;
    word_sel_t         lookup_word;
    logic              victim_rd;
    logic [1:0]        refill_en;
    logic [set_w-1:0]  refill_index;
    word_sel_t         refill_word;
    logic [word_w-1:0] refill_data;
    tag_entry_t        tag_wr;
    logic              dirty_set_on_refill;

    cache_ctrl #(.num_sets(num_sets), .line_words(line_words)) ctrl (
        .clk, .resetn, .valid, .req, .addr_ok, .data_ok, .rdata,
        .way_tag, .way_line, .way_dirty, .bank_busy, .hit_write, .hit_entry,
        .lookup_en, .lookup_index, .lookup_word, .victim_rd,
        .refill_en, .refill_index, .refill_word, .refill_data,
        .tag_wr, .dirty_set_on_refill,
        .rd_req, .rd_type, .rd_addr, .rd_rdy, .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_type, .wr_addr, .wr_wstrb, .wr_data, .wr_rdy
    );

    hit_write_buffer wbuffer (
        .clk, .resetn, .hit_write, .hit_entry,
        .req_word  (req.offset[offset_w-1:2]),                  // bank of the incoming request
        .wbuf, .pending (wbuf_pending), .bank_busy
    );

    cache_way #(.num_sets(num_sets), .line_words(line_words)) way0 (
        .clk, .resetn, .lookup_en, .lookup_index, .lookup_word, .victim_rd,
        .refill_en (refill_en[0]), .refill_index, .refill_word, .refill_data,
        .tag_wr, .dirty_set_on_refill, .wbuf, .wbuf_pending,
        .way_id    (1'b0),
        .tag_out   (way_tag[0]),
        .line_out  (way_line[0]),
        .dirty_out (way_dirty[0])
    );

    cache_way #(.num_sets(num_sets), .line_words(line_words)) way1 (
        .clk, .resetn, .lookup_en, .lookup_index, .lookup_word, .victim_rd,
        .refill_en (refill_en[1]), .refill_index, .refill_word, .refill_data,
        .tag_wr, .dirty_set_on_refill, .wbuf, .wbuf_pending,
        .way_id    (1'b1),
        .tag_out   (way_tag[1]),
        .line_out  (way_line[1]),
        .dirty_out (way_dirty[1])
    );

endmodule

`default_nettype wire

//--- design/cache_ctrl.sv
`default_nettype none

module cache_ctrl #(
    parameter int  num_sets   = 256,
    parameter int  line_words = 4,
    localparam int set_w      = $clog2(num_sets)
) (
    input  wire                               clk,
    input  wire                               resetn,
    input  wire                               valid,
    input  wire cache_pkg::cpu_req_t          req,
    output logic                              addr_ok,
    output logic                              data_ok,
    output logic [cache_pkg::word_w-1:0]      rdata,
    input  wire cache_pkg::tag_entry_t [1:0]  way_tag,
    input  wire cache_pkg::line_t [1:0]       way_line,
    input  wire [1:0]                         way_dirty,
    input  wire                               bank_busy,
    output logic                              hit_write,
    output cache_pkg::way_wr_t                hit_entry,
    output logic                              lookup_en,
    output logic [set_w-1:0]                  lookup_index,
    output cache_pkg::word_sel_t              lookup_word,
    output logic                              victim_rd,
    output logic [1:0]                        refill_en,
    output logic [set_w-1:0]                  refill_index,
    output cache_pkg::word_sel_t              refill_word,
    output logic [cache_pkg::word_w-1:0]      refill_data,
    output cache_pkg::tag_entry_t             tag_wr,
    output logic                              dirty_set_on_refill,
    output logic                              rd_req,
    output logic [2:0]                        rd_type,
    output logic [31:0]                       rd_addr,
    input  wire                               rd_rdy,
    input  wire                               ret_valid,
    input  wire                               ret_last,
    input  wire [31:0]                        ret_data,
    output logic                              wr_req,
    output logic [2:0]                        wr_type,
    output logic [31:0]                       wr_addr,
    output logic [3:0]                        wr_wstrb,
    output cache_pkg::line_t                  wr_data,
    input  wire                               wr_rdy
);
    import cache_pkg::*;

    cache_state_t      state_q;
    cache_state_t      state_d;
    cpu_req_t          req_q;
    word_sel_t         req_word;
    word_sel_t         in_word;
    logic [1:0]        way_hit;
    logic              cache_hit;
    logic              accept;
    logic              lookup_conflict;
    logic              victim_way;
    logic              victim_way_q;
    logic              replace_first_q;
    word_sel_t         cnt_q;
    logic              last_beat;
    logic [word_w-1:0] hit_word;
    logic [word_w-1:0] wmask;
    tag_entry_t        victim_tag;

    assign req_word = req_q.offset[offset_w-1:2];
    assign in_word  = req.offset[offset_w-1:2];

    assign way_hit[0] = way_tag[0].valid && (way_tag[0].tag == req_q.tag);
    assign way_hit[1] = way_tag[1].valid && (way_tag[1].tag == req_q.tag);
    assign cache_hit  = |way_hit;

    assign hit_write       = (state_q == s_lookup) && cache_hit && (req_q.op == op_write);
    assign lookup_conflict = hit_write && (in_word == req_word);  // buffered case is bank_busy
    assign addr_ok         = ((state_q == s_idle) || (state_q == s_lookup && cache_hit))
                          && !lookup_conflict && !bank_busy;
    assign accept          = valid && addr_ok;

    assign hit_word = way_line[way_hit[1]][word_w*req_word +: word_w];
    assign rdata    = (state_q == s_refill) ? ret_data : hit_word;
    assign data_ok  = ((state_q == s_lookup) && (cache_hit || req_q.op == op_write))
                   || ((state_q == s_refill) && ret_valid && (cnt_q == req_word)
                       && (req_q.op == op_read));

    assign hit_entry = '{index: req_q.index, way: way_hit[1], word: req_word,
                         wstrb: req_q.wstrb, wdata: req_q.wdata};

    // first invalid way, else way 0
    assign victim_way = way_tag[0].valid && !way_tag[1].valid;
    assign victim_tag = way_tag[victim_way];

    assign lookup_en    = accept;
    assign lookup_index = req.index[set_w-1:0];
    assign lookup_word  = in_word;
    assign victim_rd    = (state_q == s_miss) && wr_rdy;      // read whole victim line

    assign refill_en[0] = (state_q == s_refill) && ret_valid && !victim_way_q;
    assign refill_en[1] = (state_q == s_refill) && ret_valid && victim_way_q;
    assign refill_index = req_q.index[set_w-1:0];
    assign refill_word  = cnt_q;
    assign wmask        = {{8{req_q.wstrb[3]}}, {8{req_q.wstrb[2]}},
                           {8{req_q.wstrb[1]}}, {8{req_q.wstrb[0]}}};
    assign refill_data  = (req_q.op == op_write && cnt_q == req_word)
                        ? ((ret_data & ~wmask) | (req_q.wdata & wmask))
                        : ret_data;
    assign tag_wr              = '{tag: req_q.tag, valid: 1'b1};
    assign dirty_set_on_refill = (req_q.op == op_write);
    assign last_beat = ret_valid && (ret_last || (cnt_q == word_sel_t'(line_words - 1)));

    assign rd_req  = (state_q == s_replace);
    assign rd_type = burst_line;
    assign rd_addr = {req_q.tag, req_q.index, {offset_w{1'b0}}};

    assign wr_req   = replace_first_q && way_dirty[victim_way];  // victim outputs valid now
    assign wr_type  = burst_line;
    assign wr_addr  = {victim_tag.tag, req_q.index, {offset_w{1'b0}}};
    assign wr_wstrb = 4'b1111;
    assign wr_data  = way_line[victim_way];

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            s_idle:
            begin
                if (accept)
                    state_d = s_lookup;
            end
            s_lookup:
            begin
                if (!cache_hit)
                    state_d = s_miss;
                else if (!accept)
                    state_d = s_idle;
            end
            s_miss:
            begin
                if (wr_rdy)
                    state_d = s_replace;
            end
            s_replace:
            begin
                if (rd_rdy)
                    state_d = s_refill;
            end
            s_refill:
            begin
                if (last_beat)
                    state_d = s_idle;
            end
            default: state_d = s_idle;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state_q         <= s_idle;
            replace_first_q <= 1'b0;
            victim_way_q    <= 1'b0;
            cnt_q           <= '0;
        end
        else
        begin
            state_q         <= state_d;
            replace_first_q <= victim_rd;
            if (replace_first_q)
                victim_way_q <= victim_way;                     // held for the refill
            if (state_q == s_replace)
                cnt_q <= '0;
            else if (state_q == s_refill && ret_valid)
                cnt_q <= cnt_q + 2'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            req_q <= req;
    end

endmodule

`default_nettype wire

//--- design/hit_write_buffer.sv
`default_nettype none

module hit_write_buffer (
    input  wire                        clk,
    input  wire                        resetn,
    input  wire                        hit_write,
    input  wire cache_pkg::way_wr_t    hit_entry,
    input  wire cache_pkg::word_sel_t  req_word,
    output cache_pkg::way_wr_t         wbuf,
    output logic                       pending,
    output logic                       bank_busy
);
    import cache_pkg::*;

    wbuf_state_t state_q;
    wbuf_state_t state_d;
    way_wr_t     entry_q;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            w_idle:
            begin
                if (hit_write)
                    state_d = w_write;
            end
            w_write:
            begin
                if (!hit_write)
                    state_d = w_idle;                           // stays busy on back-to-back hits
            end
            default: state_d = w_idle;
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            state_q <= w_idle;
        else
            state_q <= state_d;
    end

    always_ff @(posedge clk)
    begin
        if (hit_write)
            entry_q <= hit_entry;
    end

    assign wbuf      = entry_q;
    assign pending   = (state_q == w_write);
    assign bank_busy = pending && (req_word == entry_q.word);   // same bank, any index or way

endmodule

`default_nettype wire

//--- design/cache_way.sv
`default_nettype none

module cache_way #(
    parameter int  num_sets   = 256,
    parameter int  line_words = 4,
    localparam int set_w      = $clog2(num_sets)
) (
    input  wire                              clk,
    input  wire                              resetn,
    input  wire                              lookup_en,
    input  wire [set_w-1:0]                  lookup_index,
    input  wire cache_pkg::word_sel_t        lookup_word,
    input  wire                              victim_rd,
    input  wire                              refill_en,
    input  wire [set_w-1:0]                  refill_index,
    input  wire cache_pkg::word_sel_t        refill_word,
    input  wire [cache_pkg::word_w-1:0]      refill_data,
    input  wire cache_pkg::tag_entry_t       tag_wr,
    input  wire                              dirty_set_on_refill,
    input  wire cache_pkg::way_wr_t          wbuf,
    input  wire                              wbuf_pending,
    input  wire                              way_id,
    output cache_pkg::tag_entry_t            tag_out,
    output cache_pkg::line_t                 line_out,
    output logic                             dirty_out
);
    import cache_pkg::*;

    logic [tag_w-1:0]    tag_mem [num_sets];
    logic [num_sets-1:0] valid_q;
    logic [num_sets-1:0] dirty_q;
    logic [tag_w-1:0]    tag_rd_q;
    logic                valid_rd_q;
    logic                dirty_rd_q;
    logic                meta_rd;
    logic [set_w-1:0]    meta_index;
    logic                wbuf_mine;
    logic [set_w-1:0]    wbuf_index;

    assign wbuf_mine  = wbuf_pending && (wbuf.way == way_id);
    assign wbuf_index = wbuf.index[set_w-1:0];
    assign meta_rd    = lookup_en || victim_rd;
    assign meta_index = lookup_en ? lookup_index : refill_index;  // victim and refill share index

    always_ff @(posedge clk)
    begin
        if (refill_en)
            tag_mem[refill_index] <= tag_wr.tag;
        if (meta_rd)
            tag_rd_q <= tag_mem[meta_index];
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            valid_q    <= '0;
            dirty_q    <= '0;
            valid_rd_q <= 1'b0;
            dirty_rd_q <= 1'b0;
        end
        else
        begin
            if (refill_en)
            begin
                valid_q[refill_index] <= tag_wr.valid;
                dirty_q[refill_index] <= dirty_set_on_refill;  // write miss leaves it dirty
            end
            if (wbuf_mine)
                dirty_q[wbuf_index] <= 1'b1;
            if (meta_rd)
            begin
                valid_rd_q <= valid_q[meta_index];
                dirty_rd_q <= dirty_q[meta_index];
            end
        end
    end

    for (genvar b = 0; b < line_words; b++)
    begin : g_bank
        logic [word_w-1:0] mem [num_sets];
        logic [word_w-1:0] rd_q;
        logic              wb_sel;
        logic              fill_sel;
        logic              bank_en;
        logic [set_w-1:0]  bank_addr;
        logic [3:0]        bank_we;
        logic [word_w-1:0] bank_din;

        // the write buffer owns the bank whenever it targets it
        assign wb_sel    = wbuf_mine && (wbuf.word == word_sel_t'(b));
        assign fill_sel  = refill_en && (refill_word == word_sel_t'(b));
        assign bank_en   = wb_sel || fill_sel || victim_rd
                        || (lookup_en && (lookup_word == word_sel_t'(b)));
        assign bank_addr = wb_sel ? wbuf_index : (lookup_en ? lookup_index : refill_index);
        assign bank_we   = wb_sel ? wbuf.wstrb : {4{fill_sel}};
        assign bank_din  = wb_sel ? wbuf.wdata : refill_data;

        always_ff @(posedge clk)
        begin
            if (bank_en)
            begin
                for (int i = 0; i < 4; i++)
                begin
                    if (bank_we[i])
                        mem[bank_addr][8*i +: 8] <= bank_din[8*i +: 8];
                end
                rd_q <= mem[bank_addr];                        // old data on a write cycle
            end
        end

        assign line_out[word_w*b +: word_w] = rd_q;
    end

    assign tag_out   = '{tag: tag_rd_q, valid: valid_rd_q};
    assign dirty_out = dirty_rd_q;

endmodule

`default_nettype wire

//--- design/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int index_w        = 8;
    localparam int tag_w          = 20;
    localparam int offset_w       = 4;
    localparam int words_per_line = 4;
    localparam int word_w         = 32;

    typedef logic [1:0] word_sel_t;                          // word in line, also bank number
    typedef logic [words_per_line*word_w-1:0] line_t;

    typedef enum logic {op_read = 1'b0, op_write = 1'b1} mem_op_t;

    typedef enum logic [2:0] {s_idle, s_lookup, s_miss, s_replace, s_refill} cache_state_t;

    typedef enum logic {w_idle, w_write} wbuf_state_t;

    typedef struct packed {
        mem_op_t             op;
        logic [index_w-1:0]  index;
        logic [tag_w-1:0]    tag;
        logic [offset_w-1:0] offset;
        logic [3:0]          wstrb;
        logic [word_w-1:0]   wdata;
    } cpu_req_t;

    typedef struct packed {
        logic [index_w-1:0] index;
        logic               way;
        word_sel_t          word;
        logic [3:0]         wstrb;
        logic [word_w-1:0]  wdata;
    } way_wr_t;

    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic             valid;
    } tag_entry_t;

    localparam logic [2:0] burst_line = 3'b100;              // whole-line burst on the bus

endpackage

`default_nettype wire
